/* logic/mmu_pkg.sv */
// mmu shared definitions
`default_nettype none

package mmu_pkg;

    // address and entry sizes
    localparam int VADDR_W     = 32;
    localparam int VPPN_W      = 19;   // one entry maps an even/odd page pair
    localparam int PPN_W       = 20;
    localparam int ASID_W      = 10;
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam int PAGE_OFS_W  = 12;   // 4 KiB pages only

    // tlbelo field positions
    localparam int LO_V       = 0;
    localparam int LO_D       = 1;
    localparam int LO_PLV_LSB = 2;     // plv is bits 3:2
    localparam int LO_G       = 6;
    localparam int LO_PPN_LSB = 8;     // ppn is bits 27:8

    // direct mapped window register fields
    localparam int DMW_PLV0     = 0;
    localparam int DMW_PLV3     = 3;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_VSEG_LSB = 29;

    // architectural exception codes
    localparam logic [5:0] ECODE_TLBR = 6'h3f;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PME  = 6'h04;
    localparam logic [5:0] ECODE_PPI  = 6'h07;

    // one half of an entry, 24 bits
    typedef struct packed {
        logic             v;
        logic             d;
        logic [1:0]       plv;
        logic [PPN_W-1:0] ppn;
    } page_t;

    typedef struct packed {
        logic              e;      // entry exists
        logic              g;      // global, asid ignored
        logic [ASID_W-1:0] asid;
        logic [VPPN_W-1:0] vppn;
        page_t             even;
        page_t             odd;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* logic/tlb_array.sv */
// tlb entry storage
`default_nettype none
`timescale 1ns/1ps

module tlb_array (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire                                  wr_en,
    input  wire  [mmu_pkg::TLB_IDX_W-1:0]        wr_index,
    input  wire  [mmu_pkg::VPPN_W-1:0]           wr_vppn,
    input  wire  [mmu_pkg::ASID_W-1:0]           wr_asid,
    input  wire                                  wr_e,
    input  wire  [31:0]                          wr_lo0,
    input  wire  [31:0]                          wr_lo1,
    input  wire  [mmu_pkg::ASID_W-1:0]           asid,
    input  wire  [mmu_pkg::VADDR_W-1:0]          s0_vaddr,
    output logic                                 s0_found,
    output mmu_pkg::page_t                       s0_page,
    input  wire  [mmu_pkg::VADDR_W-1:0]          s1_vaddr,
    output logic                                 s1_found,
    output mmu_pkg::page_t                       s1_page
);

    mmu_pkg::tlb_entry_t entries [mmu_pkg::TLB_ENTRIES];
    mmu_pkg::tlb_entry_t wr_entry;

    logic [mmu_pkg::VADDR_W-1:0] s_vaddr [2];
    logic                        s_found [2];
    mmu_pkg::page_t              s_page  [2];

    // unpack one tlbelo word into a page half
    function automatic mmu_pkg::page_t lo_to_page(input logic [31:0] lo);
        mmu_pkg::page_t pg;
        pg.v   = lo[mmu_pkg::LO_V];
        pg.d   = lo[mmu_pkg::LO_D];
        pg.plv = lo[mmu_pkg::LO_PLV_LSB +: 2];
        pg.ppn = lo[mmu_pkg::LO_PPN_LSB +: mmu_pkg::PPN_W];
        return pg;
    endfunction

    always_comb begin
        wr_entry.e    = wr_e;
        wr_entry.g    = wr_lo0[mmu_pkg::LO_G] & wr_lo1[mmu_pkg::LO_G];  // both halves must agree
        wr_entry.asid = wr_asid;
        wr_entry.vppn = wr_vppn;
        wr_entry.even = lo_to_page(wr_lo0);
        wr_entry.odd  = lo_to_page(wr_lo1);
    end

    // only the exist bits come out of reset cleared
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    assign s_vaddr[0] = s0_vaddr;   // fetch side
    assign s_vaddr[1] = s1_vaddr;   // data side

    for (genvar p = 0; p < 2; p++) begin : g_search
        logic [mmu_pkg::TLB_ENTRIES-1:0] hit;
        mmu_pkg::page_t                  sel;

        always_comb begin
            for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
                hit[i] = entries[i].e
                      && (entries[i].g || entries[i].asid == asid)
                      && entries[i].vppn
                         == s_vaddr[p][mmu_pkg::VADDR_W-1 -: mmu_pkg::VPPN_W];
            end
        end

        // walk down so the lowest matching index is the one left
        always_comb begin
            sel = '0;
            for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
                if (hit[i]) begin
                    sel = s_vaddr[p][mmu_pkg::PAGE_OFS_W] ? entries[i].odd
                                                          : entries[i].even;
                end
            end
        end

        assign s_found[p] = |hit;
        assign s_page[p]  = sel;
    end

    assign s0_found = s_found[0];
    assign s0_page  = s_page[0];
    assign s1_found = s_found[1];
    assign s1_page  = s_page[1];

endmodule

`default_nettype wire

/* logic/dmw_match.sv */
// direct mapped window check
`default_nettype none
`timescale 1ns/1ps

module dmw_match (
    input  wire  [mmu_pkg::VADDR_W-1:0] vaddr,
    input  wire  [1:0]                  plv,
    input  wire  [mmu_pkg::VADDR_W-1:0] dmw0,
    input  wire  [mmu_pkg::VADDR_W-1:0] dmw1,
    output logic                        hit,
    output logic [mmu_pkg::VADDR_W-1:0] paddr
);

    logic [mmu_pkg::VADDR_W-1:0] dmw [2];
    logic [1:0]                  win_hit;
    logic [mmu_pkg::VADDR_W-1:0] remap [2];

    assign dmw[0] = dmw0;
    assign dmw[1] = dmw1;

    for (genvar w = 0; w < 2; w++) begin : g_win
        logic plv_ok;

        // window enabled for kernel or user level only
        assign plv_ok = (dmw[w][mmu_pkg::DMW_PLV0] && plv == 2'd0)
                     || (dmw[w][mmu_pkg::DMW_PLV3] && plv == 2'd3);

        assign win_hit[w] = plv_ok
            && dmw[w][mmu_pkg::VADDR_W-1:mmu_pkg::DMW_VSEG_LSB]
               == vaddr[mmu_pkg::VADDR_W-1:mmu_pkg::DMW_VSEG_LSB];

        // pseg replaces the top segment bits
        assign remap[w] = {dmw[w][mmu_pkg::DMW_PSEG_LSB +: mmu_pkg::VADDR_W - mmu_pkg::DMW_VSEG_LSB],
                           vaddr[mmu_pkg::DMW_VSEG_LSB-1:0]};
    end

    assign hit   = |win_hit;
    assign paddr = win_hit[0] ? remap[0] : remap[1];  // dmw0 wins

endmodule

`default_nettype wire

/* logic/xlate_port.sv */
// address translation port
`default_nettype none
`timescale 1ns/1ps

module xlate_port #(
    parameter bit FETCH_PORT = 1'b0
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         req,
    input  wire  [mmu_pkg::VADDR_W-1:0] vaddr,
    input  wire                         store,
    input  wire                         crmd_da,
    input  wire                         crmd_pg,
    input  wire  [1:0]                  crmd_plv,
    input  wire  [mmu_pkg::VADDR_W-1:0] dmw0,
    input  wire  [mmu_pkg::VADDR_W-1:0] dmw1,
    input  wire                         tlb_found,
    input  wire  mmu_pkg::page_t        tlb_page,
    output logic                        ack,
    output logic [mmu_pkg::VADDR_W-1:0] paddr,
    output logic                        exc,
    output logic [5:0]                  ecode
);

    logic                        pg_mode;
    logic                        take;
    logic                        dmw_hit;
    logic [mmu_pkg::VADDR_W-1:0] dmw_paddr;
    logic [mmu_pkg::VADDR_W-1:0] tlb_paddr;
    logic                        tlb_exc;
    logic [5:0]                  tlb_ecode;
    logic [mmu_pkg::VADDR_W-1:0] nxt_paddr;
    logic                        nxt_exc;
    logic [5:0]                  nxt_ecode;

    assign pg_mode = crmd_pg & ~crmd_da;  // anything else is direct
    assign take    = req & ~ack;          // new request sampled this edge

    dmw_match u_dmw (
        .vaddr (vaddr),
        .plv   (crmd_plv),
        .dmw0  (dmw0),
        .dmw1  (dmw1),
        .hit   (dmw_hit),
        .paddr (dmw_paddr)
    );

    assign tlb_paddr = {tlb_page.ppn, vaddr[mmu_pkg::PAGE_OFS_W-1:0]};

    // exception priority: refill, invalid, privilege, then modify on data side
    always_comb begin
        tlb_exc = 1'b1;
        if (!tlb_found) begin
            tlb_ecode = mmu_pkg::ECODE_TLBR;
        end else if (!tlb_page.v) begin
            if (FETCH_PORT) begin
                tlb_ecode = mmu_pkg::ECODE_PIF;
            end else begin
                tlb_ecode = store ? mmu_pkg::ECODE_PIS : mmu_pkg::ECODE_PIL;
            end
        end else if (crmd_plv > tlb_page.plv) begin
            tlb_ecode = mmu_pkg::ECODE_PPI;
        end else if (!FETCH_PORT && store && !tlb_page.d) begin
            tlb_ecode = mmu_pkg::ECODE_PME;  // first write to a clean page
        end else begin
            tlb_exc   = 1'b0;
            tlb_ecode = 6'd0;
        end
    end

    always_comb begin
        if (!pg_mode) begin
            nxt_paddr = vaddr;
            nxt_exc   = 1'b0;
            nxt_ecode = 6'd0;
        end else if (dmw_hit) begin
            nxt_paddr = dmw_paddr;
            nxt_exc   = 1'b0;
            nxt_ecode = 6'd0;
        end else begin
            nxt_paddr = tlb_paddr;
            nxt_exc   = tlb_exc;
            nxt_ecode = tlb_ecode;
        end
    end

    // four phase handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
            exc <= 1'b0;
        end else if (take) begin
            ack <= 1'b1;
            exc <= nxt_exc;
        end else if (!req) begin
            ack <= 1'b0;   // drop one edge after req seen low
        end
    end

    // result held while ack is high
    always_ff @(posedge clk) begin
        if (take) begin
            paddr <= nxt_paddr;
            ecode <= nxt_ecode;
        end
    end

endmodule

`default_nettype wire

/* logic/mmu_top.sv */
// mmu front end top level
`default_nettype none
`timescale 1ns/1ps

module mmu_top (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           crmd_da,
    input  wire                           crmd_pg,
    input  wire  [1:0]                    crmd_plv,
    input  wire  [mmu_pkg::ASID_W-1:0]    asid,
    input  wire  [mmu_pkg::VADDR_W-1:0]   dmw0,
    input  wire  [mmu_pkg::VADDR_W-1:0]   dmw1,
    input  wire                           if_req,
    input  wire  [mmu_pkg::VADDR_W-1:0]   if_vaddr,
    output logic                          if_ack,
    output logic [mmu_pkg::VADDR_W-1:0]   if_paddr,
    output logic                          if_exc,
    output logic [5:0]                    if_ecode,
    input  wire                           dt_req,
    input  wire  [mmu_pkg::VADDR_W-1:0]   dt_vaddr,
    input  wire                           dt_store,
    output logic                          dt_ack,
    output logic [mmu_pkg::VADDR_W-1:0]   dt_paddr,
    output logic                          dt_exc,
    output logic [5:0]                    dt_ecode,
    input  wire                           wr_req,
    input  wire  [mmu_pkg::TLB_IDX_W-1:0] wr_index,
    input  wire  [mmu_pkg::VPPN_W-1:0]    wr_vppn,
    input  wire  [mmu_pkg::ASID_W-1:0]    wr_asid,
    input  wire                           wr_e,
    input  wire  [31:0]                   wr_lo0,
    input  wire  [31:0]                   wr_lo1,
    output logic                          wr_ack
);

    logic           wr_take;
    logic           if_found;
    mmu_pkg::page_t if_page;
    logic           dt_found;
    mmu_pkg::page_t dt_page;

    // write port handshake, entry lands on the same edge ack rises
    assign wr_take = wr_req & ~wr_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ack <= 1'b0;
        end else if (wr_take) begin
            wr_ack <= 1'b1;
        end else if (!wr_req) begin
            wr_ack <= 1'b0;
        end
    end

    tlb_array u_tlb (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_take),
        .wr_index (wr_index),
        .wr_vppn  (wr_vppn),
        .wr_asid  (wr_asid),
        .wr_e     (wr_e),
        .wr_lo0   (wr_lo0),
        .wr_lo1   (wr_lo1),
        .asid     (asid),
        .s0_vaddr (if_vaddr),
        .s0_found (if_found),
        .s0_page  (if_page),
        .s1_vaddr (dt_vaddr),
        .s1_found (dt_found),
        .s1_page  (dt_page)
    );

    xlate_port #(
        .FETCH_PORT (1'b1)
    ) u_if_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (if_req),
        .vaddr     (if_vaddr),
        .store     (1'b0),      // fetches never store
        .crmd_da   (crmd_da),
        .crmd_pg   (crmd_pg),
        .crmd_plv  (crmd_plv),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .tlb_found (if_found),
        .tlb_page  (if_page),
        .ack       (if_ack),
        .paddr     (if_paddr),
        .exc       (if_exc),
        .ecode     (if_ecode)
    );

    xlate_port #(
        .FETCH_PORT (1'b0)
    ) u_dt_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (dt_req),
        .vaddr     (dt_vaddr),
        .store     (dt_store),
        .crmd_da   (crmd_da),
        .crmd_pg   (crmd_pg),
        .crmd_plv  (crmd_plv),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .tlb_found (dt_found),
        .tlb_page  (dt_page),
        .ack       (dt_ack),
        .paddr     (dt_paddr),
        .exc       (dt_exc),
        .ecode     (dt_ecode)
    );

endmodule

`default_nettype wire

/* bench/mmu_properties.sv */
// translation port handshake checks
`default_nettype none
`timescale 1ns/1ps

module mmu_properties (
    input wire       clk,
    input wire       arst_n,
    input wire       req,
    input wire       ack,
    input wire       exc,
    input wire [5:0] ecode
);

    // idle port with no request stays idle
    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        !req && !ack |=> !ack)
        else $error("ack rose without a pending req");

    ack_held: assert property (@(posedge clk) disable iff (!arst_n)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    ack_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
        else $error("ack high during reset");

    // every exception carries a code
    exc_has_code: assert property (@(posedge clk) disable iff (!arst_n)
        ack && exc |-> ecode != 6'd0)
        else $error("exception reported with a zero ecode");

endmodule

bind xlate_port mmu_properties u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .ack    (ack),
    .exc    (exc),
    .ecode  (ecode)
);

`default_nettype wire

/* bench/mmu_tb.sv */
// mmu front end testbench
`default_nettype none
`timescale 1ns/1ps

module mmu_tb;

    localparam int TIMEOUT = 50;   // cycles per wait

    logic        clk, arst_n, crmd_da, crmd_pg;
    logic [1:0]  crmd_plv;
    logic [9:0]  asid;
    logic [31:0] dmw0, dmw1;
    logic        if_req, if_ack, if_exc;
    logic [31:0] if_vaddr, if_paddr;
    logic [5:0]  if_ecode;
    logic        dt_req, dt_store, dt_ack, dt_exc;
    logic [31:0] dt_vaddr, dt_paddr;
    logic [5:0]  dt_ecode;
    logic        wr_req, wr_e, wr_ack;
    logic [3:0]  wr_index;
    logic [18:0] wr_vppn;
    logic [9:0]  wr_asid;
    logic [31:0] wr_lo0, wr_lo1;

    // reference copy of the tlb
    logic        ref_e    [16];
    logic [9:0]  ref_asid [16];
    logic [18:0] ref_vppn [16];
    logic [31:0] ref_lo0  [16];
    logic [31:0] ref_lo1  [16];
    logic [31:0] lfsr;
    logic [31:0] va;
    logic [31:0] pa_hold;

    mmu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // mostly pages that were written, otherwise a random address
    function automatic logic [31:0] pick_vaddr();
        logic [3:0] k;
        k = 4'(rand_bits(4));
        if (!ref_e[k]) begin
            return rand_bits(32);
        end
        return {ref_vppn[k], 13'(rand_bits(13))};
    endfunction

    function automatic logic ack_of(input int port);
        case (port)
            0: return if_ack;
            1: return dt_ack;
            default: return wr_ack;
        endcase
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_ack(input int port, input logic level);
        int cnt;
        cnt = 0;
        while (ack_of(port) != level) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                stop_run($sformatf("ack of port %0d never reached %0b", port, level));
            end
        end
    endtask

    task automatic expect_xlate(input logic fetch, input logic [31:0] va_in, input logic st,
                                output logic [31:0] pa, output logic ex, output logic [5:0] ec);
        logic [31:0] win [2];
        logic [31:0] lo;
        int          idx;
        pa     = va_in;
        ex     = 1'b0;
        ec     = 6'd0;
        idx    = -1;
        win[0] = dmw0;
        win[1] = dmw1;
        if (crmd_pg && !crmd_da) begin
            for (int w = 1; w >= 0; w--) begin   // dmw0 checked last so it wins
                if (((win[w][0] && crmd_plv == 2'd0) || (win[w][3] && crmd_plv == 2'd3))
                    && win[w][31:29] == va_in[31:29]) begin
                    idx = w;
                end
            end
            if (idx >= 0) begin
                pa = {win[idx][27:25], va_in[28:0]};
            end else begin
                for (int i = 15; i >= 0; i--) begin
                    if (ref_e[i] && ((ref_lo0[i][6] && ref_lo1[i][6]) || ref_asid[i] == asid)
                        && ref_vppn[i] == va_in[31:13]) begin
                        idx = i;
                    end
                end
                ex = 1'b1;
                if (idx < 0) begin
                    ec = mmu_pkg::ECODE_TLBR;
                end else begin
                    lo = va_in[12] ? ref_lo1[idx] : ref_lo0[idx];
                    pa = {lo[27:8], va_in[11:0]};
                    if (!lo[0]) begin
                        ec = fetch ? mmu_pkg::ECODE_PIF
                                   : (st ? mmu_pkg::ECODE_PIS : mmu_pkg::ECODE_PIL);
                    end else if (crmd_plv > lo[3:2]) begin
                        ec = mmu_pkg::ECODE_PPI;
                    end else if (!fetch && st && !lo[1]) begin
                        ec = mmu_pkg::ECODE_PME;
                    end else begin
                        ex = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic check_result(input string name, input logic [31:0] exp_pa, input logic exp_ex,
                                input logic [5:0] exp_ec, input logic [31:0] pa, input logic ex,
                                input logic [5:0] ec);
        assert (ex == exp_ex && (!exp_ex || ec == exp_ec))
            else stop_run($sformatf("mismatch %s: expected exc %0b ecode %h, actual exc %0b ecode %h",
                                    name, exp_ex, exp_ec, ex, ec));
        // paddr means nothing under an exception
        assert (exp_ex || pa == exp_pa)
            else stop_run($sformatf("mismatch %s: expected paddr %h, actual paddr %h",
                                    name, exp_pa, pa));
    endtask

    task automatic write_entry(input logic [3:0] idx, input logic [18:0] vppn,
                               input logic [9:0] as, input logic [31:0] lo0,
                               input logic [31:0] lo1);
        wr_index = idx;
        wr_vppn  = vppn;
        wr_asid  = as;
        wr_e     = 1'b1;
        wr_lo0   = lo0;
        wr_lo1   = lo1;
        wr_req   = 1'b1;
        wait_ack(2, 1'b1);
        ref_e[idx]    = 1'b1;
        ref_vppn[idx] = vppn;
        ref_asid[idx] = as;
        ref_lo0[idx]  = lo0;
        ref_lo1[idx]  = lo1;
        wr_req = 1'b0;
        wait_ack(2, 1'b0);
    endtask

    // both ports busy in the same cycles
    task automatic translate_pair(input string name, input logic [31:0] va_if,
                                  input logic [31:0] va_dt, input logic st);
        logic [31:0] pa_if, pa_dt;
        logic        ex_if, ex_dt;
        logic [5:0]  ec_if, ec_dt;
        expect_xlate(1'b1, va_if, 1'b0, pa_if, ex_if, ec_if);
        expect_xlate(1'b0, va_dt, st, pa_dt, ex_dt, ec_dt);
        if_vaddr = va_if;
        dt_vaddr = va_dt;
        dt_store = st;
        if_req   = 1'b1;
        dt_req   = 1'b1;
        wait_ack(0, 1'b1);
        wait_ack(1, 1'b1);
        check_result({name, " fetch"}, pa_if, ex_if, ec_if, if_paddr, if_exc, if_ecode);
        check_result({name, " data"}, pa_dt, ex_dt, ec_dt, dt_paddr, dt_exc, dt_ecode);
        if_req = 1'b0;
        dt_req = 1'b0;
        wait_ack(0, 1'b0);
        wait_ack(1, 1'b0);
    endtask

    initial begin
        lfsr     = 32'h5ad3de14;
        arst_n   = 1'b0;
        {crmd_da, crmd_pg, crmd_plv, asid, dmw0, dmw1} = '0;
        {if_req, if_vaddr, dt_req, dt_vaddr, dt_store} = '0;
        {wr_req, wr_index, wr_vppn, wr_asid, wr_e, wr_lo0, wr_lo1} = '0;
        for (int i = 0; i < 16; i++) begin
            ref_e[i]    = 1'b0;
            ref_vppn[i] = '0;
            ref_asid[i] = '0;
            ref_lo0[i]  = '0;
            ref_lo1[i]  = '0;
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        crmd_da = 1'b1;
        for (int n = 0; n < 20; n++) begin
            translate_pair("direct", rand_bits(32), rand_bits(32), 1'(rand_bits(1)));
        end

        crmd_da = 1'b0;
        crmd_pg = 1'b1;
        for (int n = 0; n < 30; n++) begin
            dmw0     = rand_bits(32);
            dmw1     = rand_bits(32);
            crmd_plv = 1'(rand_bits(1)) ? 2'd3 : 2'd0;
            if (1'(rand_bits(1))) begin
                dmw1[31:29] = dmw0[31:29];   // overlap to exercise dmw0 priority
            end
            va = {1'(rand_bits(1)) ? dmw0[31:29] : dmw1[31:29], 29'(rand_bits(29))};
            translate_pair("window", va, {dmw1[31:29], 29'(rand_bits(29))}, 1'b0);
        end

        // windows off, everything goes through the tlb
        dmw0 = '0;
        dmw1 = '0;
        asid = 10'(rand_bits(10));
        for (int n = 0; n < 12; n++) begin
            write_entry(4'(rand_bits(4)), 19'(rand_bits(19)),
                        1'(rand_bits(1)) ? asid : 10'(rand_bits(10)),
                        rand_bits(32), rand_bits(32));
        end
        for (int n = 0; n < 80; n++) begin
            if (n == 50) begin
                asid = 10'(rand_bits(10));   // foreign asid, only global pages left
            end
            crmd_plv = 2'(rand_bits(2));
            translate_pair("tlb", pick_vaddr(), pick_vaddr(), 1'(rand_bits(1)));
        end

        crmd_plv = 2'd0;
        va       = {19'(rand_bits(19)), 13'(rand_bits(13))};
        write_entry(4'd0, va[31:13], asid, rand_bits(32) | 32'h1, rand_bits(32) | 32'h1);
        translate_pair("before rewrite", va, va, 1'b0);
        write_entry(4'd0, va[31:13], asid, rand_bits(32) | 32'h1, rand_bits(32) | 32'h1);
        translate_pair("after rewrite", va, va, 1'b0);

        // back-pressure, then ack must fall one edge after req drops
        dt_vaddr = va;
        dt_store = 1'b0;
        dt_req   = 1'b1;
        wait_ack(1, 1'b1);
        pa_hold  = dt_paddr;
        dt_vaddr = va ^ 32'h0000_1000;   // other half, must not be taken while held
        repeat (3) @(negedge clk);
        assert (dt_ack && dt_paddr == pa_hold)
            else stop_run("data port did not hold ack and paddr while req stayed high");
        dt_req = 1'b0;
        @(negedge clk);
        assert (!dt_ack)
            else stop_run("data port ack still high one edge after req dropped");

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* mmu.f */
logic/mmu_pkg.sv
logic/tlb_array.sv
logic/dmw_match.sv
logic/xlate_port.sv
logic/mmu_top.sv
bench/mmu_properties.sv
bench/mmu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module mmu_tb -f mmu.f &&
./obj_dir/Vmmu_tb | tee /dev/stderr | grep "Test OK" > /dev/null &&
exit 0 || exit 1
